//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := gpu_tb
FILELIST  := gpu_top.f
SIM_ARGS  := +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf obj_dir

//--- compute_core.sv
`default_nettype none

module compute_core import gpu_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,

    input  wire         insn_load,
    input  wire pc_t    insn_load_counter,
    input  wire insn_t  insn_bus,

    input  wire         init_r0_flag,
    input  wire word_t  init_r0_data,

    input  wire         core_start,
    output logic        core_ready,

    output mem_req_t    mem_req,
    input  wire         mem_ready,
    input  wire word_t  mem_rd_data
);

    core_state_e state;
    pc_t         pc;
    insn_t       ir;
    insn_t       imem [prog_depth];
    word_t       rf [4];

    logic        last_pc;
    logic        rf_we;
    word_t       rf_wdata;
    word_t       mem_sum;

    assign last_pc    = (pc == pc_t'(prog_depth - 1));
    assign mem_sum    = rf[ir.rs] + word_t'(ir.imm);
    assign core_ready = (state == halted);

    // the program arrives as a broadcast, one word per cycle.
    always_ff @(posedge clk) begin
        if (insn_load) begin
            imem[insn_load_counter] <= insn_bus;
        end
    end

    // register write data for the instruction that completes this cycle.
    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = rf[ir.rd];
        if (state == exec) begin
            case (ir.opcode)
                op_ldi: begin
                    rf_we    = 1'b1;
                    rf_wdata = word_t'(ir.imm);
                end
                op_add: begin
                    rf_we    = 1'b1;
                    rf_wdata = rf[ir.rd] + rf[ir.rs];
                end
                op_addi: begin
                    rf_we    = 1'b1;
                    rf_wdata = rf[ir.rd] + word_t'(ir.imm);
                end
                default: begin
                    rf_we = 1'b0;
                end
            endcase
        end else if (state == mem_wait && mem_ready && ir.opcode == op_ld) begin
            rf_we    = 1'b1;
            rf_wdata = mem_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (init_r0_flag) begin
            rf[0] <= init_r0_data;
        end else if (rf_we) begin
            rf[ir.rd] <= rf_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch) begin
            ir <= imem[pc];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= halted;
            pc      <= '0;
            mem_req <= '0;
        end else begin
            case (state)
                halted: begin
                    if (core_start) begin
                        pc    <= '0;
                        state <= fetch;
                    end
                end
                fetch: begin
                    state <= exec;
                end
                exec: begin
                    case (ir.opcode)
                        op_ld, op_st: begin
                            mem_req.en   <= 1'b1;
                            mem_req.we   <= (ir.opcode == op_st);
                            mem_req.addr <= addr_t'(mem_sum);
                            mem_req.data <= rf[ir.rd];
                            state        <= mem_wait;
                        end
                        op_halt: begin
                            state <= halted;
                        end
                        default: begin
                            pc    <= pc + 1'b1;
                            state <= last_pc ? halted : fetch;
                        end
                    endcase
                end
                mem_wait: begin
                    // the request is held unchanged until the memory answers.
                    if (mem_ready) begin
                        mem_req.en <= 1'b0;
                        pc         <= pc + 1'b1;
                        state      <= last_pc ? halted : fetch;
                    end
                end
                default: begin
                    state <= halted;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- gpu_assert.sv
`default_nettype none

module gpu_assert import gpu_pkg::*; (
    input wire                 clk,
    input wire                 rst_n,
    input wire                 start,
    input wire                 done,
    input wire mem_req_t       mem_req [num_cores],
    input wire [num_cores-1:0] mem_ready,
    input wire word_t          mem_rd_data [num_cores]
);

    logic busy;
    int   since_start;
    logic err_idle = 1'b0;
    logic err_done = 1'b0;
    logic err_grant = 1'b0;
    logic err_wait [num_cores] = '{default: 1'b0};
    logic err_data [num_cores] = '{default: 1'b0};
    logic any_fail;
    logic [num_cores-1:0] req_en;

    // busy covers the span from a start pulse to its done pulse.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            since_start <= 0;
        end else if (start && !busy) begin
            busy        <= 1'b1;
            since_start <= 0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            since_start <= since_start + 1;
        end
    end

    always_comb begin
        any_fail = err_idle | err_done | err_grant;
        for (int i = 0; i < num_cores; i++) begin
            any_fail = any_fail | err_wait[i] | err_data[i];
        end
    end

    always_comb begin
        for (int i = 0; i < num_cores; i++) begin
            req_en[i] = mem_req[i].en;
        end
    end

    // outside a task there is no done and no memory grant.
    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> (!done && (mem_ready == '0)))
        else begin $error("done or mem_ready outside a task"); err_idle = 1'b1; end

    // load and init must both have passed before done.
    a_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (since_start >= prog_depth + 2))
        else begin $error("done came too early"); err_done = 1'b1; end

    // a ready pulse answers a request that is still held, so no core is granted twice.
    a_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(mem_ready) && ((mem_ready & ~req_en) == '0))
        else begin $error("mem_ready to several cores or without a request"); err_grant = 1'b1; end

    for (genvar i = 0; i < num_cores; i++) begin : g_core
        int    wait_cnt;
        word_t stored;

        always_ff @(posedge clk) begin
            if (!rst_n || mem_ready[i] || !mem_req[i].en) begin
                wait_cnt <= 0;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end

        // the test program loads back the word this core stored last.
        always_ff @(posedge clk) begin
            if (mem_ready[i] && mem_req[i].we) begin
                stored <= mem_req[i].data;
            end
        end

        a_wait: assert property (@(posedge clk) disable iff (!rst_n)
            wait_cnt <= num_cores + 1)
            else begin $error("memory request waited too long"); err_wait[i] = 1'b1; end

        a_data: assert property (@(posedge clk) disable iff (!rst_n)
            (mem_ready[i] && !mem_req[i].we) |-> (mem_rd_data[i] == stored))
            else begin $error("load did not return the stored word"); err_data[i] = 1'b1; end
    end

endmodule

bind gpu_top gpu_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .mem_req     (mem_req),
    .mem_ready   (mem_ready),
    .mem_rd_data (mem_rd_data)
);

`default_nettype wire

//--- gpu_pkg.sv
`default_nettype none

package gpu_pkg;

    localparam int num_cores  = 4;
    localparam int prog_depth = 16;
    localparam int data_depth = 64;

    typedef logic [15:0] word_t;
    typedef logic [5:0]  addr_t;
    typedef logic [3:0]  pc_t;
    typedef logic [1:0]  reg_idx_t;
    typedef logic [1:0]  core_id_t;

    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_ldi  = 4'h1,
        op_add  = 4'h2,
        op_addi = 4'h3,
        op_ld   = 4'h4,
        op_st   = 4'h5,
        op_halt = 4'h6
    } opcode_e;

    // for ld and st the address is rs plus imm, and st stores rd.
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        logic [7:0] imm;
    } insn_t;

    typedef struct packed {
        logic  en;
        logic  we;
        addr_t addr;
        word_t data;
    } mem_req_t;

    typedef enum logic [2:0] {
        idle,
        load,
        init,
        run,
        finish
    } sched_state_e;

    typedef enum logic [1:0] {
        halted,
        fetch,
        exec,
        mem_wait
    } core_state_e;

endpackage

`default_nettype wire

//--- gpu_tb.sv
`default_nettype none

module gpu_tb import gpu_pkg::*; ();

    localparam int num_runs   = 3;
    localparam int max_cycles = num_runs * (prog_depth + 2 + 40 * num_cores);

    logic        clk;
    logic        rst_n;
    logic        prog_we;
    pc_t         prog_addr;
    insn_t       prog_data;
    logic        r0_we;
    core_id_t    r0_core;
    word_t       r0_data;
    logic        start;
    logic        done;
    addr_t       rd_addr;
    word_t       rd_data;
    logic [31:0] lfsr;

    gpu_top dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[6:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return bits;
    endfunction

    // r1 = k + r0 is stored at r0, then reloaded into r2, incremented and stored at r0 + 1.
    function automatic insn_t prog_word(input pc_t pc, input logic [3:0] k);
        case (pc)
            4'd0:    return '{op_ldi,  2'd1, 2'd0, {4'h0, k}};
            4'd1:    return '{op_add,  2'd1, 2'd0, 8'd0};
            4'd2:    return '{op_st,   2'd1, 2'd0, 8'd0};
            4'd3:    return '{op_ld,   2'd2, 2'd0, 8'd0};
            4'd4:    return '{op_addi, 2'd2, 2'd0, 8'd1};
            4'd5:    return '{op_st,   2'd2, 2'd0, 8'd1};
            default: return '{op_halt, 2'd0, 2'd0, 8'd0};
        endcase
    endfunction

    task automatic check_word(input addr_t addr, input word_t expected);
        @(posedge clk);
        rd_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        assert (rd_data === expected) else begin
            $display("FAILED rd_data at address %h: expected %h, got %h", addr, expected, rd_data);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic run_once();
        logic [7:0] k;
        logic [7:0] hi;
        logic [7:0] nib;
        word_t      r0 [num_cores];
        k = take_bits(4);
        // bits 5:4 of R0 hold the core number, so each core owns a 16-word region.
        for (int c = 0; c < num_cores; c++) begin
            hi  = take_bits(2);
            nib = take_bits(4);
            if (nib[3:0] == 4'hf) begin
                nib = 8'h0e;
            end
            r0[c] = {8'h00, hi[1:0], 2'(c), nib[3:0]};
        end
        for (int p = 0; p < prog_depth; p++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= pc_t'(p);
            prog_data <= prog_word(pc_t'(p), k[3:0]);
        end
        for (int c = 0; c < num_cores; c++) begin
            @(posedge clk);
            prog_we <= 1'b0;
            r0_we   <= 1'b1;
            r0_core <= core_id_t'(c);
            r0_data <= r0[c];
        end
        @(posedge clk);
        r0_we <= 1'b0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do @(negedge clk); while (!done);
        for (int c = 0; c < num_cores; c++) begin
            check_word(addr_t'(r0[c]), word_t'(k) + r0[c]);
            check_word(addr_t'(r0[c] + 16'd1), word_t'(k) + r0[c] + 16'd1);
        end
    endtask

    initial begin
        lfsr      = 32'h2789;
        rst_n     <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        r0_we     <= 1'b0;
        r0_core   <= '0;
        r0_data   <= '0;
        start     <= 1'b0;
        rd_addr   <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < num_runs; r++) begin
            run_once();
        end
        @(negedge clk);
        if (dut.u_assert.any_fail) begin
            $display("tests failed");
            $fatal(1, "a bound assertion failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (dut.u_assert.any_fail) begin
            $display("a bound assertion failed");
            $display("tests failed");
            $fatal(1);
        end
    end

    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("timeout: the runs did not finish within %0d cycles", max_cycles);
        $display("tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- gpu_top.f
gpu_pkg.sv
task_scheduler.sv
compute_core.sv
shared_mem.sv
gpu_top.sv
gpu_assert.sv
gpu_tb.sv

//--- gpu_top.sv
`default_nettype none

module gpu_top import gpu_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,

    input  wire             prog_we,
    input  wire pc_t        prog_addr,
    input  wire insn_t      prog_data,
    input  wire             r0_we,
    input  wire core_id_t   r0_core,
    input  wire word_t      r0_data,
    input  wire             start,
    output logic            done,

    input  wire addr_t      rd_addr,
    output word_t           rd_data
);

    logic                   insn_load;
    pc_t                    insn_load_counter;
    insn_t                  insn_bus;
    logic [num_cores-1:0]   init_r0_flag;
    word_t                  init_r0_data [num_cores];
    logic                   core_start;
    logic [num_cores-1:0]   core_ready;

    mem_req_t               mem_req [num_cores];
    logic [num_cores-1:0]   mem_ready;
    word_t                  mem_rd_data [num_cores];

    task_scheduler u_sched (
        .clk               (clk),
        .rst_n             (rst_n),
        .prog_we           (prog_we),
        .prog_addr         (prog_addr),
        .prog_data         (prog_data),
        .r0_we             (r0_we),
        .r0_core           (r0_core),
        .r0_data           (r0_data),
        .start             (start),
        .core_ready        (core_ready),
        .done              (done),
        .core_start        (core_start),
        .insn_load         (insn_load),
        .insn_load_counter (insn_load_counter),
        .insn_bus          (insn_bus),
        .init_r0_flag      (init_r0_flag),
        .init_r0_data      (init_r0_data)
    );

    for (genvar i = 0; i < num_cores; i++) begin : core_array
        compute_core u_core (
            .clk               (clk),
            .rst_n             (rst_n),
            .insn_load         (insn_load),
            .insn_load_counter (insn_load_counter),
            .insn_bus          (insn_bus),
            .init_r0_flag      (init_r0_flag[i]),
            .init_r0_data      (init_r0_data[i]),
            .core_start        (core_start),
            .core_ready        (core_ready[i]),
            .mem_req           (mem_req[i]),
            .mem_ready         (mem_ready[i]),
            .mem_rd_data       (mem_rd_data[i])
        );
    end

    shared_mem u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req     (mem_req),
        .mem_ready   (mem_ready),
        .mem_rd_data (mem_rd_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

//--- shared_mem.sv
`default_nettype none

module shared_mem import gpu_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire mem_req_t           mem_req [num_cores],
    output logic [num_cores-1:0]    mem_ready,
    output word_t                   mem_rd_data [num_cores],

    input  wire addr_t              rd_addr,
    output word_t                   rd_data
);

    word_t    ram [data_depth];
    core_id_t ptr;
    logic     gnt_any;
    core_id_t gnt_id;
    mem_req_t gnt_req;

    // round-robin search starting at the pointer.
    // a core whose ready pulse is out now still shows en, so it is skipped.
    always_comb begin
        core_id_t idx;
        gnt_any = 1'b0;
        gnt_id  = ptr;
        for (int i = 0; i < num_cores; i++) begin
            idx = ptr + core_id_t'(i);
            if (!gnt_any && mem_req[idx].en && !mem_ready[idx]) begin
                gnt_any = 1'b1;
                gnt_id  = idx;
            end
        end
    end

    assign gnt_req = mem_req[gnt_id];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr       <= '0;
            mem_ready <= '0;
        end else begin
            mem_ready <= '0;
            if (gnt_any) begin
                mem_ready[gnt_id] <= 1'b1;
                ptr               <= gnt_id + 1'b1;
            end
        end
    end

    // the access happens on the grant edge, so data and ready appear together.
    always_ff @(posedge clk) begin
        if (gnt_any) begin
            if (gnt_req.we) begin
                ram[gnt_req.addr] <= gnt_req.data;
            end
            mem_rd_data[gnt_id] <= ram[gnt_req.addr];
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= ram[rd_addr];
    end

endmodule

`default_nettype wire

//--- task_scheduler.sv
`default_nettype none

module task_scheduler import gpu_pkg::*; (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         prog_we,
    input  wire pc_t                    prog_addr,
    input  wire insn_t                  prog_data,
    input  wire                         r0_we,
    input  wire core_id_t               r0_core,
    input  wire word_t                  r0_data,
    input  wire                         start,
    input  wire [num_cores-1:0]         core_ready,

    output logic                        done,
    output logic                        core_start,
    output logic                        insn_load,
    output pc_t                         insn_load_counter,
    output insn_t                       insn_bus,
    output logic [num_cores-1:0]        init_r0_flag,
    output word_t                       init_r0_data [num_cores]
);

    sched_state_e state;
    pc_t          load_cnt;
    insn_t        prog_mem [prog_depth];

    // host side program store and R0 table.
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
        if (r0_we) begin
            init_r0_data[r0_core] <= r0_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= idle;
            load_cnt   <= '0;
            core_start <= 1'b0;
        end else begin
            core_start <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        load_cnt <= '0;
                        state    <= load;
                    end
                end
                load: begin
                    load_cnt <= load_cnt + 1'b1;
                    if (load_cnt == pc_t'(prog_depth - 1)) begin
                        state <= init;
                    end
                end
                init: begin
                    // the start pulse lands in the first run cycle.
                    core_start <= 1'b1;
                    state      <= run;
                end
                run: begin
                    // ready is still high from the idle cores while the start pulse is out.
                    if (!core_start && (&core_ready)) begin
                        state <= finish;
                    end
                end
                finish: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    assign insn_load         = (state == load);
    assign insn_load_counter = load_cnt;
    assign insn_bus          = prog_mem[load_cnt];
    assign init_r0_flag      = {num_cores{state == init}};
    assign done              = (state == finish);

endmodule

`default_nettype wire
